//--- Bender.yml
package:
  name: npu

export_include_dirs:
  - hdl

sources:
  - hdl/npu_pkg.sv
  - hdl/npu_regs.sv
  - hdl/mac_stage.sv
  - hdl/act_stage.sv
  - hdl/pool_stage.sv
  - hdl/npu_top.sv
  - target: test
    files:
      - sim/npu_tb.sv

//--- hdl/act_stage.sv
/*
 * Activation stage
 * Requantizing shift, ReLU or leaky ReLU, saturation to 8 bits
 */
`timescale 1ns/1ps
`include "npu_defs.svh"

`default_nettype none

module act_stage
    import npu_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire npu_cfg_t    cfg,
    input  wire acc_beat_t   acc_in,
    output act_beat_t        act_out
);

    localparam logic signed [`NPU_ACC_W-1:0] SAT_MAX = 127;
    localparam logic signed [`NPU_ACC_W-1:0] SAT_MIN = -128;

    logic signed [`NPU_ACC_W-1:0]  acc_s;
    logic signed [`NPU_ACC_W-1:0]  shifted;
    logic signed [`NPU_ACC_W-1:0]  activated;
    logic signed [`NPU_DATA_W-1:0] sat;
    logic signed [`NPU_DATA_W-1:0] data_q;
    logic                          valid_q;

    always_comb begin
        acc_s   = acc_in.acc;
        shifted = acc_s >>> cfg.shift;
        activated = shifted;
        if (shifted < 0) begin
            if (cfg.act_func == ACT_RELU)
                activated = '0;
            else if (cfg.act_func == ACT_LEAKY)
                activated = shifted >>> 3;
        end
        // Clamp to int8
        if (activated > SAT_MAX)
            sat = SAT_MAX[`NPU_DATA_W-1:0];
        else if (activated < SAT_MIN)
            sat = SAT_MIN[`NPU_DATA_W-1:0];
        else
            sat = activated[`NPU_DATA_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= acc_in.valid;
    end

    always_ff @(posedge clk) begin
        if (acc_in.valid)
            data_q <= sat;
    end

    assign act_out = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

//--- hdl/mac_stage.sv
/*
 * Four-lane signed MAC
 * Registers each beat's lane-product sum, then accumulates over a burst
 * and emits the total one cycle after the last beat is sampled
 */
`timescale 1ns/1ps
`include "npu_defs.svh"

`default_nettype none

module mac_stage
    import npu_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire npu_cfg_t                       cfg,
    input  wire                                 in_valid,
    input  wire                                 in_last,
    input  wire [`NPU_LANES*`NPU_DATA_W-1:0]    in_act,
    input  wire [`NPU_LANES*`NPU_DATA_W-1:0]    in_wgt,
    output acc_beat_t                           acc_out
);

    logic signed [2*`NPU_DATA_W-1:0] lane_prod;
    logic signed [`NPU_ACC_W-1:0]    beat_sum;
    logic signed [`NPU_ACC_W-1:0]    sum_q;
    logic                            sum_valid_q;
    logic                            sum_last_q;
    logic signed [`NPU_ACC_W-1:0]    acc_q;
    logic signed [`NPU_ACC_W-1:0]    acc_next;
    logic signed [`NPU_ACC_W-1:0]    total_q;
    logic                            valid_q;

    // Sum of the lane products for this beat
    always_comb begin
        beat_sum = '0;
        lane_prod = '0;
        for (int i = 0; i < `NPU_LANES; i++) begin
            lane_prod = $signed(in_act[i*`NPU_DATA_W +: `NPU_DATA_W])
                      * $signed(in_wgt[i*`NPU_DATA_W +: `NPU_DATA_W]);
            beat_sum = beat_sum + lane_prod;
        end
        acc_next = acc_q + sum_q;
    end

    // ========================================
    // Product stage
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid_q <= 1'b0;
            sum_last_q  <= 1'b0;
        end else begin
            sum_valid_q <= cfg.enable && in_valid;
            sum_last_q  <= in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            sum_q <= beat_sum;
    end

    // ========================================
    // Accumulate stage
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!cfg.enable) begin
                acc_q <= '0;
            end else if (sum_valid_q) begin
                // Start the next burst from zero
                acc_q   <= sum_last_q ? '0 : acc_next;
                valid_q <= sum_last_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.enable && sum_valid_q && sum_last_q)
            total_q <= acc_next;
    end

    assign acc_out = '{valid: valid_q, acc: total_q};

    // Bursts carry at least two beats
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        acc_out.valid |=> !acc_out.valid);

endmodule

`default_nettype wire

//--- hdl/npu_defs.svh
/*
 * NPU shared parameters
 * Lane count, datapath widths, register map and version word
 */
`ifndef NPU_DEFS_SVH
`define NPU_DEFS_SVH

// Datapath sizing
`define NPU_LANES       4
`define NPU_DATA_W      8
`define NPU_ACC_W       24
`define NPU_SHIFT_W     5

// Register map, one 32-bit word per address
`define NPU_REG_ADDR_W      4
`define NPU_REG_CTRL        4'h0
`define NPU_REG_IRQ_EN      4'h1
`define NPU_REG_IRQ_STATUS  4'h2
`define NPU_REG_VERSION     4'h3
`define NPU_REG_OUT_COUNT   4'h4

// Major 1, minor 0
`define NPU_VERSION     32'h0001_0000

`endif

//--- hdl/npu_pkg.sv
/*
 * NPU types
 * Function encodings and the beat structs passed along the pipeline
 */
`include "npu_defs.svh"

`default_nettype none

package npu_pkg;

    // Fourth code falls back to no function
    typedef enum logic [1:0] {
        ACT_NONE  = 2'd0,
        ACT_RELU  = 2'd1,
        ACT_LEAKY = 2'd2
    } act_func_e;

    typedef enum logic {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } pool_func_e;

    // Configuration seen by every stage
    typedef struct packed {
        logic                      enable;
        act_func_e                 act_func;
        pool_func_e                pool_func;
        logic [`NPU_SHIFT_W-1:0]   shift;
    } npu_cfg_t;

    // Dot-product result, MAC to activation
    typedef struct packed {
        logic                          valid;
        logic signed [`NPU_ACC_W-1:0]  acc;
    } acc_beat_t;

    // Requantized result, activation to pooling
    typedef struct packed {
        logic                           valid;
        logic signed [`NPU_DATA_W-1:0]  data;
    } act_beat_t;

endpackage

`default_nettype wire

//--- hdl/npu_regs.sv
/*
 * NPU register block
 * Control and interrupt registers, version, pooled output count
 */
`timescale 1ns/1ps
`include "npu_defs.svh"

`default_nettype none

module npu_regs
    import npu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         reg_wr,
    input  wire [`NPU_REG_ADDR_W-1:0]   reg_addr,
    input  wire [31:0]                  reg_wdata,
    input  wire                         out_valid,
    output logic [31:0]                 reg_rdata,
    output npu_cfg_t                    cfg,
    output logic                        irq
);

    logic [8:0]  ctrl_q;
    logic        irq_en_q;
    logic        irq_sts_q;
    logic [15:0] out_count_q;

    // ========================================
    // Register writes
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            irq_en_q <= 1'b0;
        end else if (reg_wr) begin
            case (reg_addr)
                `NPU_REG_CTRL:   ctrl_q   <= reg_wdata[8:0];
                `NPU_REG_IRQ_EN: irq_en_q <= reg_wdata[0];
                default: ;
            endcase
        end
    end

    // Sticky done flag, new output beats a same-cycle W1C
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_sts_q <= 1'b0;
        end else if (out_valid) begin
            irq_sts_q <= 1'b1;
        end else if (reg_wr && reg_addr == `NPU_REG_IRQ_STATUS && reg_wdata[0]) begin
            irq_sts_q <= 1'b0;
        end
    end

    // Wraps at 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_count_q <= '0;
        end else if (out_valid) begin
            out_count_q <= out_count_q + 16'd1;
        end
    end

    // ========================================
    // Read decode and outputs
    // ========================================
    always_comb begin
        case (reg_addr)
            `NPU_REG_CTRL:       reg_rdata = {23'b0, ctrl_q};
            `NPU_REG_IRQ_EN:     reg_rdata = {31'b0, irq_en_q};
            `NPU_REG_IRQ_STATUS: reg_rdata = {31'b0, irq_sts_q};
            `NPU_REG_VERSION:    reg_rdata = `NPU_VERSION;
            `NPU_REG_OUT_COUNT:  reg_rdata = {16'b0, out_count_q};
            default:             reg_rdata = '0;
        endcase
    end

    assign cfg = '{enable:    ctrl_q[0],
                   act_func:  act_func_e'(ctrl_q[2:1]),
                   pool_func: pool_func_e'(ctrl_q[3]),
                   shift:     ctrl_q[8:4]};

    assign irq = irq_sts_q & irq_en_q;

    // Interrupt rises only on a new output or when it is unmasked
    a_irq_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> $past(out_valid || (reg_wr && reg_addr == `NPU_REG_IRQ_EN)));

endmodule

`default_nettype wire

//--- hdl/npu_top.sv
/*
 * NPU compute pipeline top
 * Register block beside the MAC, activation and pooling stages
 */
`timescale 1ns/1ps
`include "npu_defs.svh"

`default_nettype none

module npu_top
    import npu_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst_n,
    // Register port
    input  wire                                 reg_wr,
    input  wire [`NPU_REG_ADDR_W-1:0]           reg_addr,
    input  wire [31:0]                          reg_wdata,
    output logic [31:0]                         reg_rdata,
    // Input beats
    input  wire                                 in_valid,
    input  wire                                 in_last,
    input  wire [`NPU_LANES*`NPU_DATA_W-1:0]    in_act,
    input  wire [`NPU_LANES*`NPU_DATA_W-1:0]    in_wgt,
    // Pooled output
    output logic                                out_valid,
    output logic signed [`NPU_DATA_W-1:0]       out_data,
    output logic                                irq
);

    npu_cfg_t  cfg;
    acc_beat_t acc_beat;
    act_beat_t act_beat;

    // ========================================
    // Control
    // ========================================
    npu_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .out_valid (out_valid),
        .reg_rdata (reg_rdata),
        .cfg       (cfg),
        .irq       (irq)
    );

    // ========================================
    // Datapath
    // ========================================
    mac_stage u_mac (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .in_valid (in_valid),
        .in_last  (in_last),
        .in_act   (in_act),
        .in_wgt   (in_wgt),
        .acc_out  (acc_beat)
    );

    act_stage u_act (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .acc_in  (acc_beat),
        .act_out (act_beat)
    );

    pool_stage u_pool (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .act_in    (act_beat),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- hdl/pool_stage.sv
/*
 * Pooling stage
 * Reduces each pair of consecutive results by max or floor average
 */
`timescale 1ns/1ps
`include "npu_defs.svh"

`default_nettype none

module pool_stage
    import npu_pkg::*;
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire npu_cfg_t                   cfg,
    input  wire act_beat_t                  act_in,
    output logic                            out_valid,
    output logic signed [`NPU_DATA_W-1:0]   out_data
);

    logic                           phase_q;
    logic                           take;
    logic signed [`NPU_DATA_W-1:0]  first_q;
    logic signed [`NPU_DATA_W-1:0]  cur;
    logic signed [`NPU_DATA_W:0]    pair_sum;
    logic signed [`NPU_DATA_W-1:0]  pooled;

    assign take = act_in.valid && cfg.enable;

    always_comb begin
        cur      = act_in.data;
        pair_sum = {first_q[`NPU_DATA_W-1], first_q} + {cur[`NPU_DATA_W-1], cur};
        if (cfg.pool_func == POOL_AVG)
            pooled = pair_sum[`NPU_DATA_W:1];
        else
            pooled = (cur > first_q) ? cur : first_q;
    end

    // Phase high means the first of a pair is held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take && phase_q;
            if (!cfg.enable)
                phase_q <= 1'b0;
            else if (act_in.valid)
                phase_q <= !phase_q;
        end
    end

    always_ff @(posedge clk) begin
        if (take && !phase_q)
            first_q <= cur;
        if (take && phase_q)
            out_data <= pooled;
    end

    // Pooled value lies between the two results of its pair
    a_pair_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_data >= $past(first_q) || out_data >= $past(cur))
                   && (out_data <= $past(first_q) || out_data <= $past(cur)));

endmodule

`default_nettype wire

//--- sim/npu_tb.sv
/*
 * NPU testbench
 * Table of pooled dot-product pairs checked against a reference model,
 * plus register, interrupt and disable behavior
 */
`timescale 1ns/1ps
`include "npu_defs.svh"

`default_nettype none

module npu_tb
    import npu_pkg::*;
();

    localparam int N_DIRECTED     = 8;
    localparam int N_ROWS         = 16;
    localparam int TIMEOUT_CYCLES = N_ROWS * 4 + 200;

    // One pooled output, beat k is dot k/2, beat k%2
    typedef struct packed {
        logic [3:0][31:0]  act;
        logic [3:0][31:0]  wgt;
        logic [1:0]        act_func;
        logic              pool_func;
        logic [4:0]        shift;
        logic signed [7:0] exp_out;
    } pool_row_t;

    logic                         clk;
    logic                         rst_n;
    logic                         reg_wr;
    logic [`NPU_REG_ADDR_W-1:0]   reg_addr;
    logic [31:0]                  reg_wdata;
    logic [31:0]                  reg_rdata;
    logic                         in_valid;
    logic                         in_last;
    logic [31:0]                  in_act;
    logic [31:0]                  in_wgt;
    logic                         out_valid;
    logic signed [7:0]            out_data;
    logic                         irq;

    pool_row_t rows [N_ROWS];
    int        errors;
    int        checks;
    int        tests;
    int        err_mark;
    int        n_outputs;
    int        cycle_count;
    int        x;
    int        y;

    npu_top npu_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_act    (in_act),
        .in_wgt    (in_wgt),
        .out_valid (out_valid),
        .out_data  (out_data),
        .irq       (irq)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic int dot_model(input logic [31:0] a, input logic [31:0] w);
        int s;
        s = 0;
        for (int i = 0; i < 4; i++)
            s += $signed(a[8*i +: 8]) * $signed(w[8*i +: 8]);
        return s;
    endfunction

    function automatic int act_model(input int acc, input logic [1:0] func,
                                     input logic [4:0] shift);
        int v;
        v = acc >>> shift;
        if (v < 0 && func == ACT_RELU)
            v = 0;
        else if (v < 0 && func == ACT_LEAKY)
            v = v >>> 3;
        // Saturate to int8
        if (v > 127)
            v = 127;
        else if (v < -128)
            v = -128;
        return v;
    endfunction

    function automatic int pool_model(input int a, input int b, input logic pool);
        if (pool == POOL_AVG)
            return (a + b) >>> 1;
        return (a > b) ? a : b;
    endfunction

    // ========================================
    // Stimulus and checks
    // ========================================
    task automatic load_row(input int idx, input logic [0:3][31:0] a,
                            input logic [0:3][31:0] w, input logic [1:0] func,
                            input logic pool, input logic [4:0] shift);
        for (int k = 0; k < 4; k++) begin
            rows[idx].act[k] = a[k];
            rows[idx].wgt[k] = w[k];
        end
        rows[idx].act_func  = func;
        rows[idx].pool_func = pool;
        rows[idx].shift     = shift;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // All tasks start and end 2 ns after a rising edge
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #2;
        reg_wr = 1'b0;
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] exp,
                              input string name);
        reg_addr = addr;
        #1;
        check_eq(name, reg_rdata, exp);
        @(posedge clk);
        #2;
    endtask

    task automatic send_beat(input logic [31:0] a, input logic [31:0] w,
                             input logic last);
        in_valid = 1'b1;
        in_last  = last;
        in_act   = a;
        in_wgt   = w;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic idle_check(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            checks++;
            assert (!out_valid) else begin
                $display("Unexpected out_valid pulse with no complete pair");
                errors++;
            end
            #1;
        end
    endtask

    task automatic run_pair(input int idx);
        pool_row_t r;
        int        lat;
        r = rows[idx];
        write_reg(`NPU_REG_CTRL, {23'b0, r.shift, r.pool_func, r.act_func, 1'b1});
        for (int k = 0; k < 4; k++)
            send_beat(r.act[k], r.wgt[k], k % 2 == 1);
        // Every completed pair yields one pooled output
        n_outputs++;
        // Count edges after the one that sampled the last beat
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!out_valid && lat < 10);
        checks++;
        assert (out_valid) else begin
            $display("No pooled output within %0d cycles for row %0d", lat, idx);
            errors++;
        end
        if (out_valid) begin
            check_eq("latency", lat, 3);
            check_eq("out_data", {{24{out_data[7]}}, out_data},
                     {{24{r.exp_out[7]}}, r.exp_out});
        end
        #1;
        // Let the register block see the pulse
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-40s %s", name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_act    = '0;
        in_wgt    = '0;
        void'($urandom(32'he191));

        // Directed rows: saturation, ReLU, leaky, large shift, mixed-sign average
        load_row(0, {32'h01020304, 32'h02020202, 32'hFFFEFDFC, 32'h04030201},
                 {32'h01010101, 32'h03030303, 32'h01010101, 32'h02020202},
                 ACT_NONE, POOL_MAX, 5'd0);
        load_row(1, {32'h80808080, 32'h10F0207F, 32'h05FB0A01, 32'hFF00FF00},
                 {32'h7F7F7F7F, 32'h11223344, 32'h0302FE01, 32'h01020304},
                 ACT_NONE, POOL_MAX, 5'd0);
        load_row(2, {32'h7F7F7F7F, 32'h7F7F7F7F, 32'h80808080, 32'h40404040},
                 {32'h7F7F7F7F, 32'h7F7F7F7F, 32'h7F7F7F7F, 32'h40404040},
                 ACT_NONE, POOL_MAX, 5'd2);
        load_row(3, {32'h80808080, 32'h80808080, 32'h10203040, 32'h01010101},
                 {32'h01010101, 32'h01010101, 32'h01010101, 32'h01020304},
                 ACT_RELU, POOL_MAX, 5'd4);
        load_row(4, {32'h80808080, 32'h9C9C9C9C, 32'h20202020, 32'h0A0A0A0A},
                 {32'h7F7F7F7F, 32'h64646464, 32'h02020202, 32'h03030303},
                 ACT_LEAKY, POOL_AVG, 5'd1);
        load_row(5, {32'h00000003, 32'h00000000, 32'h000000F8, 32'h00000000},
                 {32'h00000001, 32'h00000000, 32'h00000001, 32'h00000000},
                 ACT_NONE, POOL_AVG, 5'd0);
        load_row(6, {32'hF0E0D0C0, 32'h11223344, 32'h0F1E2D3C, 32'hC0C0C0C0},
                 {32'h05050505, 32'hFAFAFAFA, 32'h09090909, 32'h03030303},
                 ACT_RELU, POOL_AVG, 5'd3);
        load_row(7, {32'h7F7F7F7F, 32'h7F7F7F7F, 32'h80808080, 32'h80808080},
                 {32'h7F7F7F7F, 32'h7F7F7F7F, 32'h7F7F7F7F, 32'h7F7F7F7F},
                 2'd3, POOL_MAX, 5'd20);
        for (int i = N_DIRECTED; i < N_ROWS; i++) begin
            for (int k = 0; k < 4; k++) begin
                rows[i].act[k] = $urandom;
                rows[i].wgt[k] = $urandom;
            end
            rows[i].act_func  = $urandom % 4;
            rows[i].pool_func = $urandom % 2;
            rows[i].shift     = $urandom % 12;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            x = act_model(dot_model(rows[i].act[0], rows[i].wgt[0])
                          + dot_model(rows[i].act[1], rows[i].wgt[1]),
                          rows[i].act_func, rows[i].shift);
            y = act_model(dot_model(rows[i].act[2], rows[i].wgt[2])
                          + dot_model(rows[i].act[3], rows[i].wgt[3]),
                          rows[i].act_func, rows[i].shift);
            rows[i].exp_out = pool_model(x, y, rows[i].pool_func);
        end

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Register map, CTRL keeps bits 8:0 only
        write_reg(`NPU_REG_CTRL, 32'hFFFF_F1A4);
        expect_reg(`NPU_REG_CTRL, 32'h0000_01A4, "ctrl");
        write_reg(`NPU_REG_IRQ_EN, 32'h0000_0003);
        expect_reg(`NPU_REG_IRQ_EN, 32'h1, "irq_en");
        write_reg(`NPU_REG_VERSION, 32'h1234_5678);
        expect_reg(`NPU_REG_VERSION, `NPU_VERSION, "version");
        expect_reg(4'h7, 32'h0, "unknown_7");
        expect_reg(4'hF, 32'h0, "unknown_f");
        expect_reg(`NPU_REG_OUT_COUNT, 32'h0, "out_count");
        write_reg(`NPU_REG_IRQ_EN, 32'h0);
        end_test("register readback");

        for (int i = 0; i < N_ROWS; i++) begin
            run_pair(i);
            end_test($sformatf("pair %0d act %0d pool %0d shift %0d", i,
                               rows[i].act_func, rows[i].pool_func, rows[i].shift));
        end

        // ========================================
        // Interrupt and output counter
        // ========================================
        expect_reg(`NPU_REG_OUT_COUNT, n_outputs, "out_count");
        expect_reg(`NPU_REG_IRQ_STATUS, 32'h1, "irq_status");
        check_eq("irq", irq, 1'b0);
        write_reg(`NPU_REG_IRQ_EN, 32'h1);
        check_eq("irq", irq, 1'b1);
        write_reg(`NPU_REG_IRQ_STATUS, 32'h0);
        expect_reg(`NPU_REG_IRQ_STATUS, 32'h1, "irq_status");
        write_reg(`NPU_REG_IRQ_STATUS, 32'h1);
        expect_reg(`NPU_REG_IRQ_STATUS, 32'h0, "irq_status");
        check_eq("irq", irq, 1'b0);
        run_pair(0);
        check_eq("irq", irq, 1'b1);
        expect_reg(`NPU_REG_OUT_COUNT, n_outputs, "out_count");
        write_reg(`NPU_REG_IRQ_EN, 32'h0);
        check_eq("irq", irq, 1'b0);
        end_test("interrupt and counter");

        // Half a pair, then disable to drop the held result
        write_reg(`NPU_REG_CTRL, 32'h1);
        send_beat(rows[0].act[0], rows[0].wgt[0], 1'b0);
        send_beat(rows[0].act[1], rows[0].wgt[1], 1'b1);
        idle_check(4);
        write_reg(`NPU_REG_CTRL, 32'h0);
        for (int k = 0; k < 4; k++)
            send_beat(rows[2].act[k], rows[2].wgt[k], k % 2 == 1);
        idle_check(6);
        expect_reg(`NPU_REG_OUT_COUNT, n_outputs, "out_count");
        run_pair(1);
        expect_reg(`NPU_REG_OUT_COUNT, n_outputs, "out_count");
        end_test("disable and re-enable");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/npu_pkg.sv
hdl/npu_regs.sv
hdl/mac_stage.sv
hdl/act_stage.sv
hdl/pool_stage.sv
hdl/npu_top.sv
sim/npu_tb.sv
